// ==== Bender.yml ====
package:
  name: exec_core

sources:
  - hdl/rv_exec_pkg.sv
  - hdl/control_unit.sv
  - hdl/reg_file.sv
  - hdl/alu.sv
  - hdl/branch_res.sv
  - hdl/dmem_lane.sv
  - hdl/execute_stage.sv
  - hdl/exec_core.sv
  - target: simulation
    files:
      - sim/exec_core_asserts.sv
      - sim/tb_exec_core.sv

// ==== hdl/alu.sv ====
/*
  RV32I ALU with add, sub, shifts, compares and logic ops
*/
`timescale 1ns/1ps

module alu (
  input  rv_exec_pkg::alu_op_e alu_op,
  input  rv_exec_pkg::word_t   port_a,
  input  rv_exec_pkg::word_t   port_b,
  output rv_exec_pkg::word_t   port_out
);

  logic [4:0] shamt;

  // Shift amount from the low bits only
  assign shamt = port_b[4:0];

  always_comb begin
    case (alu_op)
      rv_exec_pkg::ALU_ADD:  port_out = port_a + port_b;
      rv_exec_pkg::ALU_SUB:  port_out = port_a - port_b;
      rv_exec_pkg::ALU_SLL:  port_out = port_a << shamt;
      rv_exec_pkg::ALU_SLT:  port_out = {31'b0, $signed(port_a) < $signed(port_b)};
      rv_exec_pkg::ALU_SLTU: port_out = {31'b0, port_a < port_b};
      rv_exec_pkg::ALU_XOR:  port_out = port_a ^ port_b;
      rv_exec_pkg::ALU_SRL:  port_out = port_a >> shamt;
      rv_exec_pkg::ALU_SRA:  port_out = $unsigned($signed(port_a) >>> shamt);
      rv_exec_pkg::ALU_OR:   port_out = port_a | port_b;
      rv_exec_pkg::ALU_AND:  port_out = port_a & port_b;
      default:               port_out = '0;
    endcase
  end

endmodule

// ==== hdl/branch_res.sv ====
/*
  Branch condition check and branch/jump target adder
*/
`timescale 1ns/1ps

module branch_res (
  input  rv_exec_pkg::word_t rs1_data,
  input  rv_exec_pkg::word_t rs2_data,
  input  rv_exec_pkg::word_t pc,
  input  rv_exec_pkg::ctrl_t ctrl,
  output logic               taken,
  output rv_exec_pkg::word_t target
);

  logic cond;

  always_comb begin
    case (ctrl.branch_type)
      rv_exec_pkg::BEQ:  cond = (rs1_data == rs2_data);
      rv_exec_pkg::BNE:  cond = (rs1_data != rs2_data);
      rv_exec_pkg::BLT:  cond = ($signed(rs1_data) < $signed(rs2_data));
      rv_exec_pkg::BGE:  cond = ($signed(rs1_data) >= $signed(rs2_data));
      rv_exec_pkg::BLTU: cond = (rs1_data < rs2_data);
      rv_exec_pkg::BGEU: cond = (rs1_data >= rs2_data);
      default:           cond = 1'b0;
    endcase
  end

  // Condition only counts for a decoded branch
  assign taken = ctrl.branch & cond;

  always_comb begin
    if (ctrl.jump && ctrl.j_sel)
      target = pc + ctrl.imm_uj;
    else if (ctrl.jump)
      // JALR drops bit 0 of the sum
      target = (rs1_data + ctrl.imm_i) & ~32'h1;
    else
      target = pc + ctrl.imm_sb;
  end

endmodule

// ==== hdl/control_unit.sv ====
/*
  RV32I instruction decoder
  Maps the instruction word to control flags, selects and immediates
*/
`timescale 1ns/1ps

module control_unit (
  input  rv_exec_pkg::word_t instr,
  output rv_exec_pkg::ctrl_t ctrl
);

  logic [2:0] funct3;
  logic [6:0] funct7;

  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  always_comb begin
    ctrl = '0;
    // Register fields sit at fixed positions
    ctrl.rs1 = instr[19:15];
    ctrl.rs2 = instr[24:20];
    ctrl.rd  = instr[11:7];
    // Sign-extended immediates for every format
    ctrl.imm_i  = {{20{instr[31]}}, instr[31:20]};
    ctrl.imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    ctrl.imm_sb = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    ctrl.imm_uj = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    ctrl.imm_u  = {instr[31:12], 12'h000};
    ctrl.alu_op      = rv_exec_pkg::ALU_ADD;
    ctrl.a_sel       = rv_exec_pkg::A_RS1;
    ctrl.b_sel       = rv_exec_pkg::B_RS2;
    ctrl.w_sel       = rv_exec_pkg::W_ALU;
    ctrl.branch_type = rv_exec_pkg::branch_e'(funct3);
    ctrl.mem_size    = rv_exec_pkg::mem_size_e'(funct3);

    case (instr[6:0])
      rv_exec_pkg::OPC_LUI: begin
        ctrl.wen   = 1'b1;
        ctrl.w_sel = rv_exec_pkg::W_IMM_U;
      end
      rv_exec_pkg::OPC_AUIPC: begin
        ctrl.wen   = 1'b1;
        ctrl.a_sel = rv_exec_pkg::A_PC;
        ctrl.b_sel = rv_exec_pkg::B_IMM_U;
      end
      rv_exec_pkg::OPC_JAL: begin
        ctrl.wen   = 1'b1;
        ctrl.jump  = 1'b1;
        ctrl.j_sel = 1'b1;
        ctrl.w_sel = rv_exec_pkg::W_PC4;
      end
      rv_exec_pkg::OPC_JALR: begin
        ctrl.wen     = 1'b1;
        ctrl.jump    = 1'b1;
        ctrl.w_sel   = rv_exec_pkg::W_PC4;
        ctrl.illegal = (funct3 != 3'b000);
      end
      rv_exec_pkg::OPC_BRANCH: begin
        ctrl.branch  = 1'b1;
        // funct3 010 and 011 are reserved
        ctrl.illegal = (funct3[2:1] == 2'b01);
      end
      rv_exec_pkg::OPC_LOAD: begin
        ctrl.wen     = 1'b1;
        ctrl.dren    = 1'b1;
        ctrl.b_sel   = rv_exec_pkg::B_IMM_I;
        ctrl.w_sel   = rv_exec_pkg::W_LOAD;
        ctrl.illegal = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
      end
      rv_exec_pkg::OPC_STORE: begin
        ctrl.dwen    = 1'b1;
        ctrl.b_sel   = rv_exec_pkg::B_IMM_S;
        ctrl.illegal = funct3[2] || (funct3 == 3'b011);
      end
      rv_exec_pkg::OPC_OPIMM: begin
        ctrl.wen    = 1'b1;
        ctrl.b_sel  = rv_exec_pkg::B_IMM_I;
        // Only SRAI picks up bit 30, ADDI has no SUB form
        ctrl.alu_op = rv_exec_pkg::alu_op_e'({instr[30] & (funct3 == 3'b101), funct3});
        if (funct3 == 3'b001)
          ctrl.illegal = (funct7 != 7'b0000000);
        else if (funct3 == 3'b101)
          ctrl.illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
      end
      rv_exec_pkg::OPC_OP: begin
        ctrl.wen    = 1'b1;
        ctrl.alu_op = rv_exec_pkg::alu_op_e'({instr[30], funct3});
        // SUB and SRA are the only funct7 variants
        if (funct7 == 7'b0100000)
          ctrl.illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
        else
          ctrl.illegal = (funct7 != 7'b0000000);
      end
      rv_exec_pkg::OPC_SYSTEM: begin
        // ECALL only
        ctrl.halt    = (instr == 32'h0000_0073);
        ctrl.illegal = (instr != 32'h0000_0073);
      end
      default: ctrl.illegal = 1'b1;
    endcase

    // Unknown encodings have no side effects
    if (ctrl.illegal) begin
      ctrl.wen    = 1'b0;
      ctrl.dren   = 1'b0;
      ctrl.dwen   = 1'b0;
      ctrl.branch = 1'b0;
      ctrl.jump   = 1'b0;
    end
  end

endmodule

// ==== hdl/dmem_lane.sv ====
/*
  Data memory lane logic, little-endian
  Byte enables, store replication, misalignment and load extension
*/
`timescale 1ns/1ps

module dmem_lane (
  input  rv_exec_pkg::word_t     addr,
  input  rv_exec_pkg::mem_size_e mem_size,
  input  rv_exec_pkg::word_t     store_data,
  input  rv_exec_pkg::word_t     load_word,
  output logic [3:0]             sel,
  output rv_exec_pkg::word_t     wdata,
  output rv_exec_pkg::word_t     load_data,
  output logic                   mal
);

  logic [1:0]         offset;
  rv_exec_pkg::word_t shifted;

  assign offset = addr[1:0];

  always_comb begin
    case (mem_size)
      rv_exec_pkg::LB, rv_exec_pkg::LBU: begin
        sel   = 4'b0001 << offset;
        // Same byte on every lane, sel picks the one written
        wdata = {4{store_data[7:0]}};
        mal   = 1'b0;
      end
      rv_exec_pkg::LH, rv_exec_pkg::LHU: begin
        sel   = offset[1] ? 4'b1100 : 4'b0011;
        wdata = {2{store_data[15:0]}};
        mal   = offset[0];
      end
      rv_exec_pkg::LW: begin
        sel   = 4'b1111;
        wdata = store_data;
        mal   = (offset != 2'b00);
      end
      default: begin
        sel   = 4'b0000;
        wdata = store_data;
        mal   = 1'b0;
      end
    endcase
  end

  // Bring the addressed lane down to bit 0
  assign shifted = load_word >> {offset, 3'b000};

  always_comb begin
    case (mem_size)
      rv_exec_pkg::LB:  load_data = {{24{shifted[7]}}, shifted[7:0]};
      rv_exec_pkg::LBU: load_data = {24'b0, shifted[7:0]};
      rv_exec_pkg::LH:  load_data = {{16{shifted[15]}}, shifted[15:0]};
      rv_exec_pkg::LHU: load_data = {16'b0, shifted[15:0]};
      default:          load_data = load_word;
    endcase
  end

endmodule

// ==== hdl/exec_core.sv ====
/*
  Execute subsystem top with the fetch/execute register and halt latch
*/
`timescale 1ns/1ps

module exec_core (
  input  logic                 CLK,
  input  logic                 arst_n,
  input  logic                 in_valid,
  input  rv_exec_pkg::word_t   in_instr,
  input  rv_exec_pkg::word_t   in_pc,
  input  logic                 in_prediction,
  output logic                 in_ready,
  output logic                 dbus_cyc,
  output logic                 dbus_stb,
  output logic                 dbus_we,
  output rv_exec_pkg::word_t   dbus_adr,
  output logic [3:0]           dbus_sel,
  output rv_exec_pkg::word_t   dbus_dat_w,
  input  rv_exec_pkg::word_t   dbus_dat_r,
  input  logic                 dbus_ack,
  output logic                 retire_valid,
  output rv_exec_pkg::retire_t retire,
  output rv_exec_pkg::word_t   brj_addr,
  output logic                 mispredict,
  output logic                 halt
);

  rv_exec_pkg::fetch_ex_t fetch_ex;
  rv_exec_pkg::word_t     ex_instr, ex_pc, ex_pc4;
  logic                   ex_valid, ex_pred, stall, halt_q, xfer;

  // Closed during a bus cycle, on ECALL and after it
  assign in_ready = ~stall & ~halt & ~halt_q;
  assign xfer     = in_valid & in_ready;

  always_ff @(posedge CLK, negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
      halt_q   <= 1'b0;
    end else begin
      if (xfer)
        ex_valid <= 1'b1;
      else if (retire_valid)
        ex_valid <= 1'b0;
      if (retire_valid && halt)
        halt_q <= 1'b1;
    end
  end

  // Payload only moves on a transfer, so it holds through a stall
  always_ff @(posedge CLK) begin
    if (xfer) begin
      ex_instr <= in_instr;
      ex_pc    <= in_pc;
      ex_pc4   <= in_pc + 32'd4;
      ex_pred  <= in_prediction;
    end
  end

  assign fetch_ex = '{
    valid:      ex_valid,
    instr:      ex_instr,
    pc:         ex_pc,
    pc4:        ex_pc4,
    prediction: ex_pred
  };

  execute_stage u_ex (
    .CLK, .arst_n, .fetch_ex, .stall,
    .dbus_cyc, .dbus_stb, .dbus_we, .dbus_adr, .dbus_sel, .dbus_dat_w,
    .dbus_dat_r, .dbus_ack,
    .retire_valid, .retire, .brj_addr, .mispredict, .halt
  );

endmodule

// ==== hdl/execute_stage.sv ====
/*
  Execute stage of the two-stage RV32I pipeline
  Decode, register read, ALU, branch resolve, Wishbone data access, write-back
*/
`timescale 1ns/1ps

module execute_stage (
  input  logic                   CLK,
  input  logic                   arst_n,
  input  rv_exec_pkg::fetch_ex_t fetch_ex,
  output logic                   stall,
  output logic                   dbus_cyc,
  output logic                   dbus_stb,
  output logic                   dbus_we,
  output rv_exec_pkg::word_t     dbus_adr,
  output logic [3:0]             dbus_sel,
  output rv_exec_pkg::word_t     dbus_dat_w,
  input  rv_exec_pkg::word_t     dbus_dat_r,
  input  logic                   dbus_ack,
  output logic                   retire_valid,
  output rv_exec_pkg::retire_t   retire,
  output rv_exec_pkg::word_t     brj_addr,
  output logic                   mispredict,
  output logic                   halt
);

  typedef enum logic {IDLE, BUS} bus_state_e;

  bus_state_e         state, state_nxt;
  rv_exec_pkg::ctrl_t ctrl;
  rv_exec_pkg::word_t rs1_data, rs2_data, w_data;
  rv_exec_pkg::word_t port_a, port_b, alu_out;
  rv_exec_pkg::word_t br_target, load_data;
  logic               br_taken, lane_mal, mem_op, mal, req, ack_ok, rf_wen;

  control_unit u_cu (.instr(fetch_ex.instr), .ctrl(ctrl));

  reg_file u_rf (
    .CLK, .arst_n,
    .rs1(ctrl.rs1), .rs2(ctrl.rs2), .rd(ctrl.rd),
    .wen(rf_wen), .w_data,
    .rs1_data, .rs2_data
  );

  // Operand selects
  assign port_a = (ctrl.a_sel == rv_exec_pkg::A_PC) ? fetch_ex.pc : rs1_data;

  always_comb begin
    case (ctrl.b_sel)
      rv_exec_pkg::B_IMM_I: port_b = ctrl.imm_i;
      rv_exec_pkg::B_IMM_S: port_b = ctrl.imm_s;
      rv_exec_pkg::B_IMM_U: port_b = ctrl.imm_u;
      default:              port_b = rs2_data;
    endcase
  end

  alu u_alu (.alu_op(ctrl.alu_op), .port_a, .port_b, .port_out(alu_out));

  branch_res u_br (
    .rs1_data, .rs2_data, .pc(fetch_ex.pc), .ctrl,
    .taken(br_taken), .target(br_target)
  );

  // ALU sum is the effective address for loads and stores
  dmem_lane u_lane (
    .addr(alu_out), .mem_size(ctrl.mem_size),
    .store_data(rs2_data), .load_word(dbus_dat_r),
    .sel(dbus_sel), .wdata(dbus_dat_w), .load_data, .mal(lane_mal)
  );

  assign mem_op = ctrl.dren | ctrl.dwen;
  assign mal    = mem_op & lane_mal;
  // Misaligned accesses never reach the bus
  assign req    = fetch_ex.valid & mem_op & ~lane_mal;
  assign ack_ok = dbus_ack & dbus_stb;

  // Wishbone cycle control
  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: if (req && !ack_ok) state_nxt = BUS;
      BUS:  if (ack_ok) state_nxt = IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge CLK, negedge arst_n) begin
    if (!arst_n)
      state <= IDLE;
    else
      state <= state_nxt;
  end

  // Cycle opens with the request and holds in BUS until ack
  assign dbus_cyc = req | (state == BUS);
  assign dbus_stb = dbus_cyc;
  assign dbus_we  = ctrl.dwen;
  assign dbus_adr = {alu_out[31:2], 2'b00};
  // Covers the ack cycle too so intake stays closed
  assign stall    = dbus_cyc;

  always_comb begin
    case (ctrl.w_sel)
      rv_exec_pkg::W_LOAD:  w_data = load_data;
      rv_exec_pkg::W_PC4:   w_data = fetch_ex.pc4;
      rv_exec_pkg::W_IMM_U: w_data = ctrl.imm_u;
      default:              w_data = alu_out;
    endcase
  end

  // Memory ops retire on ack, everything else in one cycle
  assign retire_valid = fetch_ex.valid & (~req | ack_ok);
  assign rf_wen       = retire_valid & ctrl.wen & ~mal;

  assign retire = '{
    pc:      fetch_ex.pc,
    rd:      ctrl.rd,
    wdata:   w_data,
    wen:     ctrl.wen & ~mal,
    taken:   br_taken,
    mal:     mal,
    halt:    ctrl.halt,
    illegal: ctrl.illegal
  };

  // Resolved next PC
  always_comb begin
    if (!fetch_ex.valid)
      brj_addr = rv_exec_pkg::RESET_PC;
    else if (ctrl.jump || br_taken)
      brj_addr = br_target;
    else
      brj_addr = fetch_ex.pc4;
  end

  assign mispredict = fetch_ex.valid & (fetch_ex.prediction ^ (br_taken | ctrl.jump));
  assign halt       = fetch_ex.valid & ctrl.halt;

endmodule

// ==== hdl/reg_file.sv ====
/*
  Integer register file, two asynchronous reads and one write
*/
`timescale 1ns/1ps

module reg_file (
  input  logic                 CLK,
  input  logic                 arst_n,
  input  rv_exec_pkg::regidx_t rs1,
  input  rv_exec_pkg::regidx_t rs2,
  input  rv_exec_pkg::regidx_t rd,
  input  logic                 wen,
  input  rv_exec_pkg::word_t   w_data,
  output rv_exec_pkg::word_t   rs1_data,
  output rv_exec_pkg::word_t   rs2_data
);

  // x0 has no storage
  rv_exec_pkg::word_t regs [1:rv_exec_pkg::NREGS-1];

  always_ff @(posedge CLK, negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < rv_exec_pkg::NREGS; i++)
        regs[i] <= '0;
    end else if (wen && (rd != '0)) begin
      regs[rd] <= w_data;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== hdl/rv_exec_pkg.sv ====
/*
  Shared types for the RV32I execute subsystem
  Opcodes, decoder fields, pipeline register and retire record
*/
package rv_exec_pkg;

  localparam int NREGS = 32;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  regidx_t;

  // Address held on brj_addr while the stage is empty
  localparam word_t RESET_PC = 32'h0000_0000;

  // RV32I major opcodes
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OPIMM  = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // Encoded as {funct7[5], funct3}
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111,
    ALU_SUB  = 4'b1000,
    ALU_SRA  = 4'b1101
  } alu_op_e;

  // Branch condition, same code as funct3
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_e;

  // Access width and sign, same code as funct3; stores use LB, LH, LW
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } mem_size_e;

  typedef enum logic {A_RS1, A_PC} a_sel_e;
  typedef enum logic [1:0] {B_RS2, B_IMM_I, B_IMM_S, B_IMM_U} b_sel_e;
  typedef enum logic [1:0] {W_LOAD, W_PC4, W_IMM_U, W_ALU} w_sel_e;

  typedef struct packed {
    regidx_t   rs1, rs2, rd;
    logic      wen, dren, dwen;
    logic      branch, jump;
    logic      j_sel;       // 1 for JAL, 0 for JALR
    logic      halt, illegal;
    alu_op_e   alu_op;
    a_sel_e    a_sel;
    b_sel_e    b_sel;
    w_sel_e    w_sel;
    branch_e   branch_type;
    mem_size_e mem_size;
    word_t     imm_i, imm_s, imm_sb, imm_uj, imm_u;
  } ctrl_t;

  typedef struct packed {
    logic  valid;
    word_t instr;
    word_t pc;
    word_t pc4;
    logic  prediction;
  } fetch_ex_t;

  typedef struct packed {
    word_t   pc;
    regidx_t rd;
    word_t   wdata;
    logic    wen;      // Register write committed
    logic    taken;    // Conditional branch taken
    logic    mal;
    logic    halt;
    logic    illegal;
  } retire_t;

endpackage

// ==== sim/exec_core_asserts.sv ====
/*
  Wishbone and intake handshake rules for exec_core
*/
`timescale 1ns/1ps

module exec_core_asserts (
  input logic               CLK,
  input logic               arst_n,
  input logic               in_ready,
  input logic               dbus_cyc,
  input logic               dbus_stb,
  input logic               dbus_ack,
  input rv_exec_pkg::word_t dbus_adr,
  input rv_exec_pkg::word_t dbus_dat_w,
  input logic [3:0]         dbus_sel
);

  // Number of rule violations so far
  int unsigned fail_count = 0;

  // Strobe only inside a cycle
  stb_in_cyc: assert property (@(posedge CLK) disable iff (!arst_n) dbus_stb |-> dbus_cyc)
    else begin
      $error("stb high without cyc");
      fail_count++;
    end

  // Request held stable until ack
  req_stable: assert property (@(posedge CLK) disable iff (!arst_n)
    (dbus_stb && !dbus_ack) |=> (dbus_stb && $stable(dbus_adr) && $stable(dbus_dat_w)
                                 && $stable(dbus_sel)))
    else begin
      $error("bus request changed before ack");
      fail_count++;
    end

  // No intake during an open bus cycle
  no_intake: assert property (@(posedge CLK) disable iff (!arst_n) dbus_cyc |-> !in_ready)
    else begin
      $error("in_ready high during bus cycle");
      fail_count++;
    end

endmodule

bind exec_core exec_core_asserts u_asserts (.*);

// ==== sim/tb_exec_core.sv ====
/*
  Testbench for exec_core with a Wishbone memory model and an RV32I reference model
*/
`timescale 1ns/1ps

module tb_exec_core;

  typedef struct packed {
    rv_exec_pkg::retire_t r;
    rv_exec_pkg::word_t   brj;
    logic                 mis;
    logic                 halt;
  } exp_t;

  logic                 CLK, arst_n, in_valid, in_prediction, in_ready;
  rv_exec_pkg::word_t   in_instr, in_pc;
  logic                 dbus_cyc, dbus_stb, dbus_we, dbus_ack;
  rv_exec_pkg::word_t   dbus_adr, dbus_dat_w, dbus_dat_r;
  logic [3:0]           dbus_sel;
  logic                 retire_valid, mispredict, halt;
  rv_exec_pkg::retire_t retire;
  rv_exec_pkg::word_t   brj_addr;

  rv_exec_pkg::word_t mem [0:255];
  rv_exec_pkg::word_t ref_mem [0:255];
  rv_exec_pkg::word_t ref_regs [0:31];
  exp_t               exp_q [$];
  rv_exec_pkg::word_t cur_pc;
  integer             seed, bus_seed, errors, issued, retired, cycles;
  integer             bus_count, exp_bus, ack_delay, wait_cnt;

  exec_core dut_i (.*);

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  // Instruction encoders
  function automatic rv_exec_pkg::word_t enc_i(logic [11:0] imm, logic [4:0] rs1,
                                               logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic rv_exec_pkg::word_t enc_s(logic [11:0] imm, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic rv_exec_pkg::word_t enc_b(logic [12:0] imm, logic [4:0] rs2,
                                               logic [4:0] rs1, logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic rv_exec_pkg::word_t enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6F};
  endfunction

  function automatic rv_exec_pkg::word_t rnd();
    return $random(seed);
  endfunction

  // ISA reference, updates the model registers and memory
  function automatic void ref_exec(input rv_exec_pkg::word_t instr, input rv_exec_pkg::word_t pc,
                                   input logic pred, output exp_t e,
                                   output rv_exec_pkg::word_t npc);
    rv_exec_pkg::word_t a, b, immi, imms, immb, immj, immu, res, addr, sh, mask, data;
    logic [2:0] f3;
    logic       wen, jump, cond, mis_al;
    f3   = instr[14:12];
    a    = ref_regs[instr[19:15]];
    b    = ref_regs[instr[24:20]];
    immi = {{20{instr[31]}}, instr[31:20]};
    imms = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    immb = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    immj = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    immu = {instr[31:12], 12'h000};
    e = '0;
    e.r.pc = pc;
    e.r.rd = instr[11:7];
    npc  = pc + 4;
    res  = '0;
    wen  = 1'b0;
    jump = 1'b0;
    case (instr[6:0])
      7'h37: begin res = immu; wen = 1'b1; end
      7'h17: begin res = pc + immu; wen = 1'b1; end
      7'h6F: begin res = pc + 4; wen = 1'b1; jump = 1'b1; npc = pc + immj; end
      7'h67: begin res = pc + 4; wen = 1'b1; jump = 1'b1; npc = (a + immi) & ~32'h1; end
      7'h63: begin
        case (f3)
          3'd0: cond = (a == b);
          3'd1: cond = (a != b);
          3'd4: cond = ($signed(a) < $signed(b));
          3'd5: cond = ($signed(a) >= $signed(b));
          3'd6: cond = (a < b);
          default: cond = (a >= b);
        endcase
        e.r.taken = cond;
        if (cond)
          npc = pc + immb;
      end
      7'h03, 7'h23: begin
        addr   = a + ((instr[6:0] == 7'h03) ? immi : imms);
        mis_al = (f3[1:0] == 2'd1) ? addr[0] : ((f3[1:0] == 2'd2) && (addr[1:0] != 0));
        e.r.mal = mis_al;
        if (!mis_al) begin
          exp_bus++;
          sh = ref_mem[addr[9:2]] >> (addr[1:0] * 8);
          if (instr[6:0] == 7'h03) begin
            wen = 1'b1;
            case (f3)
              3'd0: res = {{24{sh[7]}}, sh[7:0]};
              3'd1: res = {{16{sh[15]}}, sh[15:0]};
              3'd4: res = {24'b0, sh[7:0]};
              3'd5: res = {16'b0, sh[15:0]};
              default: res = sh;
            endcase
          end else begin
            // Lane mask in byte positions of the addressed word
            mask = (f3 == 3'd0) ? 32'hFF : ((f3 == 3'd1) ? 32'hFFFF : 32'hFFFF_FFFF);
            mask = mask << (addr[1:0] * 8);
            data = b << (addr[1:0] * 8);
            ref_mem[addr[9:2]] = (ref_mem[addr[9:2]] & ~mask) | (data & mask);
          end
        end
      end
      7'h13, 7'h33: begin
        if (instr[6:0] == 7'h13)
          b = immi;
        wen = 1'b1;
        case (f3)
          3'd0: res = (instr[6:0] == 7'h33 && instr[30]) ? a - b : a + b;
          3'd1: res = a << b[4:0];
          3'd2: res = {31'b0, $signed(a) < $signed(b)};
          3'd3: res = {31'b0, a < b};
          3'd4: res = a ^ b;
          3'd5: res = instr[30] ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
          3'd6: res = a | b;
          default: res = a & b;
        endcase
      end
      default: begin e.halt = 1'b1; e.r.halt = 1'b1; end
    endcase
    e.r.wen   = wen;
    e.r.wdata = res;
    if (wen && instr[11:7] != 0)
      ref_regs[instr[11:7]] = res;
    e.brj = npc;
    e.mis = pred ^ (e.r.taken | jump);
  endfunction

  task automatic check_retire(string name, rv_exec_pkg::retire_t got, rv_exec_pkg::retire_t exp);
    // Write data only matters when the register is written
    if (!exp.wen)
      got.wdata = exp.wdata;
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(string name, rv_exec_pkg::word_t got, rv_exec_pkg::word_t exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Drive one instruction and hold it until accepted
  task automatic issue_instr(rv_exec_pkg::word_t instr, logic pred);
    exp_t               e;
    rv_exec_pkg::word_t npc;
    logic               ok;
    ref_exec(instr, cur_pc, pred, e, npc);
    exp_q.push_back(e);
    issued++;
    in_valid      = 1'b1;
    in_instr      = instr;
    in_pc         = cur_pc;
    in_prediction = pred;
    do begin
      @(negedge CLK);
      ok = in_ready;
      @(posedge CLK);
      #1;
    end while (!ok);
    in_valid = 1'b0;
    cur_pc   = npc;
  endtask

  // Wishbone slave with random ack delay
  always @(posedge CLK) begin
    #1;
    if (dbus_ack) begin
      dbus_ack = 1'b0;
    end else if (dbus_cyc && dbus_stb) begin
      if (wait_cnt >= ack_delay) begin
        if (dbus_we) begin
          for (int k = 0; k < 4; k++)
            if (dbus_sel[k])
              mem[dbus_adr[9:2]][8*k +: 8] = dbus_dat_w[8*k +: 8];
        end else begin
          dbus_dat_r = mem[dbus_adr[9:2]];
        end
        dbus_ack  = 1'b1;
        bus_count++;
        wait_cnt  = 0;
        ack_delay = {$random(bus_seed)} % 4;
      end else begin
        wait_cnt++;
      end
    end
  end

  // Compare every retire against the oldest expected record
  always @(negedge CLK) begin : compare_retire
    exp_t e;
    if (arst_n && retire_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Instruction retired at %0t with none outstanding", $time);
      end else begin
        e = exp_q.pop_front();
        check_retire("retire", retire, e.r);
        check_word("brj_addr", brj_addr, e.brj);
        check_bit("mispredict", mispredict, e.mis);
        check_bit("halt", halt, e.halt);
        retired++;
      end
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles > 20 * issued + 200) begin
      $display("Timeout after %0d cycles with %0d retires outstanding", cycles, exp_q.size());
      $display("Verification failed");
      $finish;
    end
  end

  initial begin
    arst_n = 1'b0;
    in_valid = 1'b0;
    in_instr = '0;
    in_pc = '0;
    in_prediction = 1'b0;
    dbus_ack = 1'b0;
    dbus_dat_r = '0;
    seed = 98164;
    bus_seed = 98164;
    errors = 0;
    issued = 0;
    retired = 0;
    cycles = 0;
    bus_count = 0;
    exp_bus = 0;
    wait_cnt = 0;
    cur_pc = 32'h0000_1000;
    ack_delay = {$random(bus_seed)} % 4;
    for (int i = 0; i < 256; i++) begin
      mem[i]     = (i + 1) * 32'h9E37_79B1;
      ref_mem[i] = mem[i];
    end
    for (int i = 0; i < 32; i++)
      ref_regs[i] = '0;
    repeat (8) @(posedge CLK);
    #1 arst_n = 1'b1;
    @(posedge CLK);
    #1;
    // Random register contents through LUI and ADDI
    for (int r = 1; r < 32; r++) begin
      issue_instr({20'(rnd() >> 12), 5'(r), 7'h37}, 1'b0);
      issue_instr(enc_i(12'(rnd()), 5'(r), 3'd0, 5'(r), 7'h13), 1'b0);
    end
    // ALU, immediates, LUI and AUIPC with x0 as a possible target
    for (int n = 0; n < 80; n++) begin : alu_loop
      logic [2:0]  f3;
      logic [11:0] imm;
      f3  = 3'(rnd());
      imm = 12'(rnd());
      if (f3 == 3'd1 || f3 == 3'd5)
        imm[11:5] = {1'b0, imm[10], 5'b0} & {1'b0, f3[2], 5'b0};
      case (n % 4)
        0: issue_instr(enc_i(imm, 5'(rnd()), f3, 5'(rnd()), 7'h13), 1'b0);
        1: issue_instr({(f3 == 0 || f3 == 5) ? {1'b0, 1'(rnd()), 5'b0} : 7'b0,
                        5'(rnd()), 5'(rnd()), f3, 5'(rnd()), 7'h33}, 1'b0);
        2: issue_instr({20'(rnd() >> 12), 5'(rnd()), 7'h37}, 1'b0);
        default: issue_instr({20'(rnd() >> 12), 5'(rnd()), 7'h17}, 1'b0);
      endcase
    end
    // Branches, JAL and JALR with random predictions
    for (int n = 0; n < 48; n++) begin : br_loop
      logic [2:0] f3;
      logic [4:0] rs1;
      f3  = 3'(rnd());
      rs1 = 5'(rnd());
      if (f3 == 3'd2 || f3 == 3'd3)
        f3 = 3'd0;
      if (n % 6 == 4)
        issue_instr(enc_j(21'(rnd()) & ~21'h1, 5'(rnd())), 1'(rnd()));
      else if (n % 6 == 5)
        issue_instr(enc_i(12'(rnd()), rs1, 3'd0, 5'(rnd()), 7'h67), 1'(rnd()));
      else
        issue_instr(enc_b(13'(rnd()) & ~13'h1, (n % 3 == 0) ? rs1 : 5'(rnd()), rs1, f3),
                    1'(rnd()));
    end
    // Stores then loads of the same word at every legal offset around base x5
    issue_instr(enc_i(12'h100, 5'd0, 3'd0, 5'd5, 7'h13), 1'b0);
    for (int g = 0; g < 3; g++) begin : mem_loop
      logic [11:0] ofs;
      for (int off = 0; off < 4; off++) begin
        ofs = 12'(({$random(seed)} % 16) * 4 + off);
        issue_instr(enc_s(ofs, 5'(6 + {$random(seed)} % 26), 5'd5, 3'd0), 1'b0);
        issue_instr(enc_i(ofs, 5'd5, 3'd0, 5'(6 + {$random(seed)} % 26), 7'h03), 1'b0);
        issue_instr(enc_i(ofs, 5'd5, 3'd4, 5'(6 + {$random(seed)} % 26), 7'h03), 1'b0);
        if (off % 2 == 0) begin
          issue_instr(enc_s(ofs, 5'(6 + {$random(seed)} % 26), 5'd5, 3'd1), 1'b0);
          issue_instr(enc_i(ofs, 5'd5, 3'd1, 5'(6 + {$random(seed)} % 26), 7'h03), 1'b0);
          issue_instr(enc_i(ofs, 5'd5, 3'd5, 5'(6 + {$random(seed)} % 26), 7'h03), 1'b0);
        end
      end
      ofs = 12'(({$random(seed)} % 16) * 4);
      issue_instr(enc_s(ofs, 5'(6 + {$random(seed)} % 26), 5'd5, 3'd2), 1'b0);
      issue_instr(enc_i(ofs, 5'd5, 3'd2, 5'(6 + {$random(seed)} % 26), 7'h03), 1'b0);
    end
    // Misaligned halfword and word accesses
    for (int off = 1; off < 4; off++) begin
      issue_instr(enc_s(12'(12'h20 + off), 5'd7, 5'd5, 3'd2), 1'b0);
      issue_instr(enc_i(12'(12'h24 + off), 5'd5, 3'd2, 5'd8, 7'h03), 1'b0);
    end
    issue_instr(enc_s(12'h31, 5'd9, 5'd5, 3'd1), 1'b0);
    issue_instr(enc_i(12'h33, 5'd5, 3'd1, 5'd10, 7'h03), 1'b0);
    issue_instr(enc_i(12'h35, 5'd5, 3'd5, 5'd11, 7'h03), 1'b0);
    // Registers touched by the misaligned loads must be unchanged
    issue_instr(enc_i(12'h000, 5'd8, 3'd0, 5'd12, 7'h13), 1'b0);
    issue_instr(enc_i(12'h000, 5'd10, 3'd0, 5'd13, 7'h13), 1'b0);
    issue_instr(32'h0000_0073, 1'b0);
    while (exp_q.size() != 0)
      @(posedge CLK);
    #1;
    // Intake must stay closed after ECALL
    in_valid = 1'b1;
    in_instr = enc_i(12'h001, 5'd1, 3'd0, 5'd1, 7'h13);
    repeat (12) begin
      @(negedge CLK);
      if (in_ready !== 1'b0) begin
        errors++;
        $display("Instruction intake open at %0t after halt", $time);
      end
    end
    in_valid = 1'b0;
    check_word("bus_count", bus_count, exp_bus);
    for (int i = 0; i < 256; i++)
      check_word("mem", mem[i], ref_mem[i]);
    // Bus and handshake rule violations seen by the bound checker
    errors += dut_i.u_asserts.fail_count;
    $display("Run done: %0d issued, %0d retired, %0d errors", issued, retired, errors);
    if (errors == 0 && retired == issued)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

// ==== tb.f ====
hdl/rv_exec_pkg.sv
hdl/control_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/branch_res.sv
hdl/dmem_lane.sv
hdl/execute_stage.sv
hdl/exec_core.sv
sim/exec_core_asserts.sv
sim/tb_exec_core.sv
